// ==== include/trace_net_defs.svh ====
/*
  Sizing macros for the trace network. Include ahead of the package and
  any module that sizes ports or arrays from the core count.
*/

`ifndef TRACE_NET_DEFS_SVH
`define TRACE_NET_DEFS_SVH

// Cores attached to the network, split evenly across two channels
`define TN_NUM_CORES 8

// Hops on one channel
`define TN_CORES_IN_PATH (`TN_NUM_CORES / 2)

// Payload width of one trace beat
`define TN_DATA_WIDTH 32

// Even cores ride the even channel, odd cores the odd one
// Hop index i maps to core 2i or 2i+1

`endif

// ==== rtl/trace_channel.sv ====
/*
  One daisy-chained trace channel. Hop 0 sits next to the funnel and the
  last hop is the tail; repeaters below each hop carry beats and control.
*/

`include "trace_net_defs.svh"

module trace_channel
  import trace_net_pkg::*;
#(
  parameter int unsigned STAGES [`TN_CORES_IN_PATH] = '{1, 1, 1, 1}
) (
  input  logic                                     clk,
  input  logic                                     rst,

  input  core_req_t  [`TN_CORES_IN_PATH-1:0]       core_req,
  output logic       [`TN_CORES_IN_PATH-1:0]       core_gnt,
  output core_ctrl_t [`TN_CORES_IN_PATH-1:0]       core_ctrl,

  output trace_beat_t                              funnel_beat,
  input  path_ctrl_t                               funnel_ctrl
);

  localparam int unsigned NUM_HOPS = `TN_CORES_IN_PATH;

  // rep_beat[i] leaves the repeater below hop i; the top entry is the tail
  trace_beat_t rep_beat [NUM_HOPS+1];
  trace_beat_t hop_beat [NUM_HOPS];

  // hop_ctrl[i] enters the repeater below hop i; entry 0 is the funnel
  path_ctrl_t  hop_ctrl [NUM_HOPS+1];
  path_ctrl_t  rep_ctrl [NUM_HOPS];

  // Nothing arrives above the tail
  assign rep_beat[NUM_HOPS] = '0;
  assign hop_ctrl[0]        = funnel_ctrl;
  assign funnel_beat        = rep_beat[0];

  for (genvar i = 0; i < NUM_HOPS; i++) begin : g_hop
    trace_hop #(
      .HOP_IDX(i)
    ) u_hop (
      .clk        (clk),
      .rst        (rst),
      .core_req   (core_req[i]),
      .core_gnt   (core_gnt[i]),
      .core_ctrl  (core_ctrl[i]),
      .upstrm_beat(rep_beat[i+1]),
      .dnstrm_beat(hop_beat[i]),
      .dnstrm_ctrl(rep_ctrl[i]),
      .upstrm_ctrl(hop_ctrl[i+1])
    );

    // Beats down toward the funnel
    trace_repeater #(
      .NUM_STAGES(STAGES[i]),
      .payload_t (trace_beat_t)
    ) u_beat_rep (
      .clk(clk),
      .rst(rst),
      .d  (hop_beat[i]),
      .q  (rep_beat[i])
    );

    // Control up toward the tail, same depth
    trace_repeater #(
      .NUM_STAGES(STAGES[i]),
      .payload_t (path_ctrl_t)
    ) u_ctrl_rep (
      .clk(clk),
      .rst(rst),
      .d  (hop_ctrl[i]),
      .q  (rep_ctrl[i])
    );
  end

endmodule

// ==== rtl/trace_hop.sv ====
/*
  One core's injection point on a channel. Forwards upstream beats first,
  otherwise grants the local core and tags its beat with the hop index.
*/

`include "trace_net_defs.svh"

module trace_hop
  import trace_net_pkg::*;
#(
  parameter int unsigned HOP_IDX = 0
) (
  input  logic        clk,
  input  logic        rst,

  // Local core
  input  core_req_t   core_req,
  output logic        core_gnt,
  output core_ctrl_t  core_ctrl,

  // Beats toward the funnel
  input  trace_beat_t upstrm_beat,
  output trace_beat_t dnstrm_beat,

  // Control toward the tail
  input  path_ctrl_t  dnstrm_ctrl,
  output path_ctrl_t  upstrm_ctrl
);

  // Tag placed on beats injected here
  localparam logic [`TN_CORES_IN_PATH-1:0] HOP_ONEHOT =
    (`TN_CORES_IN_PATH)'(1) << HOP_IDX;

  path_ctrl_t  ctrl_q;
  trace_beat_t beat_q;
  logic        upstrm_busy;
  logic        stream_bp;
  logic        core_enabled;

  // ----------------------------------------------------------------------
  // Control path
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      ctrl_q <= '0;
    end else begin
      ctrl_q <= dnstrm_ctrl;
    end
  end

  // Same registered copy feeds the core and the next hop
  assign core_ctrl   = ctrl_q.ctrl;
  assign upstrm_ctrl = ctrl_q;

  // ----------------------------------------------------------------------
  // Grant
  // ----------------------------------------------------------------------

  assign upstrm_busy  = |upstrm_beat.vld;
  assign core_enabled = ctrl_q.enabled_srcs[HOP_IDX];

  // Only the stream the core is asking for matters
  assign stream_bp = (core_req.src == SRC_DST) ? ctrl_q.ctrl.dst_bp
                                               : ctrl_q.ctrl.ntrace_bp;

  assign core_gnt = core_req.vld & core_enabled & ~stream_bp & ~upstrm_busy;

  // ----------------------------------------------------------------------
  // Output register
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      beat_q <= '0;
    end else if (upstrm_busy) begin
      // In-flight beats always win the slot
      beat_q <= upstrm_beat;
    end else if (core_gnt) begin
      beat_q.vld  <= HOP_ONEHOT;
      beat_q.src  <= core_req.src;
      beat_q.data <= core_req.data;
    end else begin
      beat_q <= '0;
    end
  end

  assign dnstrm_beat = beat_q;

endmodule

// ==== rtl/trace_net_pkg.sv ====
/*
  Packed types shared by the trace network RTL and its testbench.
  Import with a wildcard in the module header.
*/

`include "trace_net_defs.svh"

package trace_net_pkg;

  // Stream encoding on the src field
  localparam logic SRC_NTRACE = 1'b0;
  localparam logic SRC_DST    = 1'b1;

  // Beat offered by a core
  typedef struct packed {
    logic                      vld;
    logic                      src;
    logic [`TN_DATA_WIDTH-1:0] data;
  } core_req_t;

  // Level signals returned to each core
  typedef struct packed {
    logic ntrace_bp;
    logic dst_bp;
    logic ntrace_flush;
    logic dst_flush;
  } core_ctrl_t;

  // Control heading up a channel, one enable bit per hop
  typedef struct packed {
    core_ctrl_t                   ctrl;
    logic [`TN_CORES_IN_PATH-1:0] enabled_srcs;
  } path_ctrl_t;

  // Beat heading down a channel, vld is one-hot on the source hop
  typedef struct packed {
    logic [`TN_CORES_IN_PATH-1:0] vld;
    logic                         src;
    logic [`TN_DATA_WIDTH-1:0]    data;
  } trace_beat_t;

  // Funnel control, enable bits by global core number
  typedef struct packed {
    core_ctrl_t               ctrl;
    logic [`TN_NUM_CORES-1:0] enabled_srcs;
  } funnel_ctrl_t;

endpackage

// ==== rtl/trace_network.sv ====
/*
  Trace network top. Interleaves eight cores onto an even and an odd
  channel and splits the funnel's enable mask between them.
*/

`include "trace_net_defs.svh"

module trace_network
  import trace_net_pkg::*;
(
  input  logic                                 clk,
  input  logic                                 rst,

  input  core_req_t  [`TN_NUM_CORES-1:0]       core_req,
  output logic       [`TN_NUM_CORES-1:0]       core_gnt,
  output core_ctrl_t [`TN_NUM_CORES-1:0]       core_ctrl,

  output trace_beat_t                          even_beat,
  output trace_beat_t                          odd_beat,
  input  funnel_ctrl_t                         funnel_ctrl
);

  localparam int unsigned NUM_HOPS = `TN_CORES_IN_PATH;

  // Repeater depths per hop, worst path 11 cycles
  localparam int unsigned EVEN_STAGES [NUM_HOPS] = '{1, 2, 1, 3};
  localparam int unsigned ODD_STAGES  [NUM_HOPS] = '{2, 1, 3, 1};

  core_req_t  [NUM_HOPS-1:0] even_req, odd_req;
  logic       [NUM_HOPS-1:0] even_gnt, odd_gnt;
  core_ctrl_t [NUM_HOPS-1:0] even_core_ctrl, odd_core_ctrl;
  logic       [NUM_HOPS-1:0] even_en, odd_en;
  path_ctrl_t                even_ctrl, odd_ctrl;

  // ----------------------------------------------------------------------
  // Core interleave
  // ----------------------------------------------------------------------

  for (genvar i = 0; i < NUM_HOPS; i++) begin : g_split
    assign even_req[i]      = core_req[2*i];
    assign odd_req[i]       = core_req[2*i+1];
    assign core_gnt[2*i]    = even_gnt[i];
    assign core_gnt[2*i+1]  = odd_gnt[i];
    assign core_ctrl[2*i]   = even_core_ctrl[i];
    assign core_ctrl[2*i+1] = odd_core_ctrl[i];
    assign even_en[i]       = funnel_ctrl.enabled_srcs[2*i];
    assign odd_en[i]        = funnel_ctrl.enabled_srcs[2*i+1];
  end

  // Shared levels go to both channels
  assign even_ctrl = '{ctrl: funnel_ctrl.ctrl, enabled_srcs: even_en};
  assign odd_ctrl  = '{ctrl: funnel_ctrl.ctrl, enabled_srcs: odd_en};

  trace_channel #(.STAGES(EVEN_STAGES)) even_channel (
    .clk(clk), .rst(rst),
    .core_req(even_req), .core_gnt(even_gnt), .core_ctrl(even_core_ctrl),
    .funnel_beat(even_beat), .funnel_ctrl(even_ctrl)
  );

  trace_channel #(.STAGES(ODD_STAGES)) odd_channel (
    .clk(clk), .rst(rst),
    .core_req(odd_req), .core_gnt(odd_gnt), .core_ctrl(odd_core_ctrl),
    .funnel_beat(odd_beat), .funnel_ctrl(odd_ctrl)
  );

endmodule

// ==== rtl/trace_repeater.sv ====
/*
  Fixed-depth register pipeline standing in for repeaters on long routes.
  Carries either trace beats or channel control through payload_t.
*/

module trace_repeater #(
  parameter int unsigned NUM_STAGES = 1,
  parameter type         payload_t  = logic
) (
  input  logic     clk,
  input  logic     rst,
  input  payload_t d,
  output payload_t q
);

  if (NUM_STAGES == 0) begin : g_bypass
    // No repeaters on this route
    assign q = d;
  end else begin : g_pipe
    payload_t stage_q [NUM_STAGES];

    always_ff @(posedge clk) begin
      if (rst) begin
        for (int i = 0; i < NUM_STAGES; i++) begin
          stage_q[i] <= '0;
        end
      end else begin
        stage_q[0] <= d;
        for (int i = 1; i < NUM_STAGES; i++) begin
          stage_q[i] <= stage_q[i-1];
        end
      end
    end

    // Last stage drives the far end
    assign q = stage_q[NUM_STAGES-1];
  end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the trace network testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
  --top-module trace_network_tb \
  -f sim.f \
  -o Vtrace_network_tb

# The model exits non-zero on a failed check
sim_out="$(./obj_dir/Vtrace_network_tb 2>&1)" || true
printf '%s\n' "$sim_out"

if grep -qF -- '*** PASSED ***' <<< "$sim_out"; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed"
  exit 1
fi

// ==== sim.f ====
+incdir+include
rtl/trace_net_pkg.sv
rtl/trace_repeater.sv
rtl/trace_hop.sv
rtl/trace_channel.sv
rtl/trace_network.sv
verif/trace_network_tb.sv

// ==== verif/trace_network_tb.sv ====
/*
  Table-driven testbench for the trace network. Each table row sets the
  funnel control, runs core requests and scoreboards beats at the funnel.
*/

`include "trace_net_defs.svh"

module trace_network_tb
  import trace_net_pkg::*;
;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NC            = `TN_NUM_CORES;
  localparam int SETTLE_CYCLES = 16;
  localparam int NUM_ROWS      = 8;
  localparam logic [31:0] SEED = 32'hc2ada44e;

  // One phase with ctrl bits ordered {ntrace_bp, dst_bp, ntrace_flush, dst_flush}
  typedef struct packed {
    logic [NC-1:0]      req;
    logic [NC-1:0]      src;
    logic [NC-1:0][3:0] beats;
    core_ctrl_t         ctrl;
    logic [NC-1:0]      en;
  } row_t;

  localparam row_t ROWS [NUM_ROWS] = '{
    '{req: 8'h01, src: 8'h00, beats: 32'h0000_0003, ctrl: 4'b0000, en: 8'hff},
    '{req: 8'h20, src: 8'h20, beats: 32'h0030_0000, ctrl: 4'b0000, en: 8'hff},
    '{req: 8'hff, src: 8'haa, beats: 32'h4444_4444, ctrl: 4'b0000, en: 8'hff},
    '{req: 8'hff, src: 8'hf0, beats: 32'h2222_2222, ctrl: 4'b1000, en: 8'hff},
    '{req: 8'hff, src: 8'hf0, beats: 32'h2222_2222, ctrl: 4'b0100, en: 8'hff},
    '{req: 8'hff, src: 8'h3c, beats: 32'h2222_2222, ctrl: 4'b0000, en: 8'h5a},
    '{req: 8'h0f, src: 8'h00, beats: 32'h1111_1111, ctrl: 4'b0011, en: 8'hff},
    '{req: 8'hff, src: 8'h0f, beats: 32'h1111_1111, ctrl: 4'b0110, en: 8'hff}
  };

  string phase_name [NUM_ROWS] = '{"single_core0", "single_core5", "all_cores",
    "ntrace_bp", "dst_bp", "enable_mask", "flush_levels", "dst_bp_flush"};

  logic                     clk;
  logic                     rst;
  core_req_t    [NC-1:0]    core_req;
  logic         [NC-1:0]    core_gnt;
  core_ctrl_t   [NC-1:0]    core_ctrl;
  trace_beat_t              even_beat;
  trace_beat_t              odd_beat;
  funnel_ctrl_t             funnel_ctrl;

  // Scoreboard state
  trace_beat_t   exp_q [NC][$];
  int            granted_cnt [NC];
  int            presented_cnt [NC];
  int            target_cnt [NC];
  logic [NC-1:0] blocked_mask;
  logic [NC-1:0] row_src;
  logic [31:0]   rng_state;
  int            cycle_count;
  int            timeout_limit;

  trace_network dut (
    .clk(clk), .rst(rst),
    .core_req(core_req), .core_gnt(core_gnt), .core_ctrl(core_ctrl),
    .even_beat(even_beat), .odd_beat(odd_beat), .funnel_ctrl(funnel_ctrl)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ------------------------------------------------------------------
  // Helpers and compare tasks
  // ------------------------------------------------------------------

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_beat(input string name, input trace_beat_t exp, input trace_beat_t act);
    if (act !== exp) begin
      abort_run($sformatf(
        "** Error at %0d ns: %s expected vld=%b src=%b data=%h, got vld=%b src=%b data=%h",
        $time, name, exp.vld, exp.src, exp.data, act.vld, act.src, act.data));
    end
  endtask

  task automatic check_ctrl(input string name, input core_ctrl_t exp, input core_ctrl_t act);
    if (act !== exp) begin
      abort_run($sformatf("** Error at %0d ns: %s expected %b, got %b",
        $time, name, exp, act));
    end
  endtask

  task automatic check_gnt(input string name, input logic [NC-1:0] exp,
                           input logic [NC-1:0] act);
    if (act !== exp) begin
      abort_run($sformatf("** Error at %0d ns: %s expected %b, got %b",
        $time, name, exp, act));
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Funnel view of a core's beat with hop index core / 2 as one-hot
  function automatic trace_beat_t expected_beat(input int core, input core_req_t req);
    trace_beat_t b;
    b.vld  = (`TN_CORES_IN_PATH)'(1) << (core / 2);
    b.src  = req.src;
    b.data = req.data;
    return b;
  endfunction

  function automatic int timeout_cycles();
    int beats_total;
    beats_total = 0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      for (int c = 0; c < NC; c++) begin
        if (ROWS[r].req[c]) beats_total += int'(ROWS[r].beats[c]);
      end
    end
    return SETTLE_CYCLES * NUM_ROWS + 4 * beats_total + 200;
  endfunction

  // ------------------------------------------------------------------
  // Grant sampling and funnel monitor
  // ------------------------------------------------------------------

  task automatic sample_grants();
    for (int c = 0; c < NC; c++) begin
      if (core_gnt[c]) begin
        if (!core_req[c].vld) abort_run($sformatf("Core %0d granted without a request", c));
        else if (blocked_mask[c]) abort_run($sformatf("Core %0d granted while stalled", c));
        else begin
          exp_q[c].push_back(expected_beat(c, core_req[c]));
          granted_cnt[c]++;
        end
      end
    end
  endtask

  task automatic sample_funnel(input trace_beat_t beat, input int parity, input string name);
    int          hop;
    int          core;
    trace_beat_t exp;
    hop = 0;
    if (beat.vld != '0) begin
      if ($countones(beat.vld) != 1) begin
        abort_run($sformatf("%s has a vld field that is not one-hot: %b", name, beat.vld));
      end else begin
        for (int i = 0; i < `TN_CORES_IN_PATH; i++) begin
          if (beat.vld[i]) hop = i;
        end
        core = 2 * hop + parity;
        if (exp_q[core].size() == 0) begin
          abort_run($sformatf("Unexpected beat from core %0d on %s", core, name));
        end else begin
          exp = exp_q[core].pop_front();
          check_beat(name, exp, beat);
        end
      end
    end
  endtask

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > timeout_limit) begin
      abort_run($sformatf("Timeout after %0d cycles", cycle_count));
    end else if (!rst) begin
      sample_grants();
      sample_funnel(even_beat, 0, "even_beat");
      sample_funnel(odd_beat, 1, "odd_beat");
    end
  end

  // ------------------------------------------------------------------
  // Request driver and row sequencing
  // ------------------------------------------------------------------

  // A core holds its beat until granted and then offers the next one
  task automatic drive_requests();
    for (int c = 0; c < NC; c++) begin
      if (core_req[c].vld && granted_cnt[c] == presented_cnt[c]) core_req[c].vld = 1'b0;
      if (!core_req[c].vld && presented_cnt[c] < target_cnt[c]) begin
        rng_state        = xorshift32(rng_state);
        core_req[c].vld  = 1'b1;
        core_req[c].src  = row_src[c];
        core_req[c].data = rng_state;
        presented_cnt[c]++;
      end
    end
  endtask

  function automatic bit row_done();
    for (int c = 0; c < NC; c++) begin
      if (!blocked_mask[c] && (granted_cnt[c] != target_cnt[c] || exp_q[c].size() != 0))
        return 1'b0;
    end
    return 1'b1;
  endfunction

  task automatic run_row(input int r);
    row_t row;
    row = ROWS[r];
    $display("Phase %s", phase_name[r]);
    @(negedge clk);
    funnel_ctrl.ctrl         = row.ctrl;
    funnel_ctrl.enabled_srcs = row.en;
    row_src                  = row.src;
    for (int c = 0; c < NC; c++) begin
      blocked_mask[c] = row.req[c] & (~row.en[c] |
                        (row.src[c] ? row.ctrl.dst_bp : row.ctrl.ntrace_bp));
      target_cnt[c]   = granted_cnt[c] + (row.req[c] ? int'(row.beats[c]) : 0);
    end
    repeat (SETTLE_CYCLES) @(negedge clk);
    for (int c = 0; c < NC; c++) begin
      check_ctrl($sformatf("core_ctrl[%0d]", c), row.ctrl, core_ctrl[c]);
    end
    while (!row_done()) begin
      drive_requests();
      @(negedge clk);
    end
    // Lift back-pressure so the stalled requests drain
    if ((blocked_mask & row.en) != '0) begin
      funnel_ctrl.ctrl.ntrace_bp = 1'b0;
      funnel_ctrl.ctrl.dst_bp    = 1'b0;
      blocked_mask               = row.req & ~row.en;
      while (!row_done()) begin
        drive_requests();
        @(negedge clk);
      end
    end
    for (int c = 0; c < NC; c++) begin
      core_req[c]      = '0;
      presented_cnt[c] = granted_cnt[c];
      target_cnt[c]    = granted_cnt[c];
    end
  endtask

  initial begin
    timeout_limit = timeout_cycles();
    rst           = 1'b1;
    funnel_ctrl   = '0;
    blocked_mask  = '0;
    row_src       = '0;
    rng_state     = SEED;
    for (int c = 0; c < NC; c++) begin
      // Held through reset and must not be granted
      core_req[c]      = '0;
      core_req[c].vld  = 1'b1;
      presented_cnt[c] = 0;
      target_cnt[c]    = 0;
    end
    repeat (2) @(negedge clk);
    rst = 1'b0;
    check_gnt("core_gnt", '0, core_gnt);
    check_beat("even_beat", '0, even_beat);
    check_beat("odd_beat", '0, odd_beat);
    for (int c = 0; c < NC; c++) begin
      check_ctrl($sformatf("core_ctrl[%0d]", c), '0, core_ctrl[c]);
    end
    core_req = '0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      run_row(r);
    end
    // Idle tail catches stray or duplicated beats
    repeat (SETTLE_CYCLES) @(negedge clk);
    $display("*** PASSED ***");
    $finish;
  end

endmodule
